//--- build.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_fill_ctrl.sv
hdl/cache_array.sv
hdl/main_mem.sv
hdl/cache_top.sv
verif/cache_top_tb.sv

//--- hdl/cache_array.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_array (
    input  logic                 clk,
    input  logic                 reset,
    input  cache_pkg::core_req_t req,
    input  cache_pkg::fill_wr_t  fill,
    output logic                 miss,
    output cache_pkg::word_t     rdata
);
    import cache_pkg::*;

    word_t            data_arr [`SETS][`BLOCK_WORDS];
    tag_t             tag_arr  [`SETS];
    logic [`SETS-1:0] valid;

    tag_t             req_tag;
    index_t           req_idx;
    offset_t          req_off;
    tag_t             fill_tag;
    index_t           fill_idx;
    offset_t          fill_off;
    logic             hit;
    logic             store_we;

    ////////////////////
    // Address fields
    ////////////////////
    assign req_tag  = req.addr[`ADDR_W-1:`TAG_LSB];
    assign req_idx  = req.addr[`TAG_LSB-1:`INDEX_LSB];
    assign req_off  = req.addr[`INDEX_LSB-1:`OFFSET_LSB];
    assign fill_tag = fill.addr[`ADDR_W-1:`TAG_LSB];
    assign fill_idx = fill.addr[`TAG_LSB-1:`INDEX_LSB];
    assign fill_off = fill.addr[`INDEX_LSB-1:`OFFSET_LSB];

    ////////////////////
    // Lookup
    ////////////////////
    assign hit   = valid[req_idx] && (tag_arr[req_idx] == req_tag);
    assign miss  = (req.rd || req.wr) && !hit;
    assign rdata = data_arr[req_idx][req_off];

    // A held store rewrites the same word, so stall needs no gating here
    assign store_we = req.wr && hit;

    ////////////////////
    // Updates
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset)
            valid <= '0;
        else if (fill.tag_we)
            valid[fill_idx] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (fill.data_we)
            data_arr[fill_idx][fill_off] <= fill.data;
        else if (store_we)
            data_arr[req_idx][req_off] <= req.wdata;
        // Tag goes in with the last word of the block
        if (fill.tag_we)
            tag_arr[fill_idx] <= fill_tag;
    end

    // The controller only fills a cache whose request misses
    a_fill_vs_store: assert property (@(posedge clk) disable iff (reset)
        !(fill.data_we && store_we));

endmodule

//--- hdl/cache_fill_ctrl.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_fill_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                miss_i,
    input  logic                miss_d,
    input  logic                store_d,
    input  cache_pkg::addr_t    addr_i,
    input  cache_pkg::addr_t    addr_d,
    output logic                stall,
    output cache_pkg::fill_wr_t fill_i,
    output cache_pkg::fill_wr_t fill_d,
    output logic                mem_en,
    output cache_pkg::addr_t    mem_addr,
    input  cache_pkg::word_t    mem_data,
    input  logic                mem_vld
);
    import cache_pkg::*;

    fill_state_t             state;
    fill_state_t             state_nxt;
    logic [`OFFSET_W:0]      req_cnt;
    logic [`OFFSET_W-1:0]    ret_cnt;
    logic                    filling;
    logic                    last_beat;
    addr_t                   base_addr;
    addr_t                   addr_line [`MEM_LAT];
    fill_wr_t                beat;

    ////////////////////
    // FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset)
            state <= fill_idle;
        else
            state <= state_nxt;
    end

    // Port names shadow the fill_i and fill_d literals
    always_comb begin
        state_nxt = state;
        stall     = 1'b1;
        case (state)
            fill_idle: begin
                // Raise stall in the same cycle as the miss
                stall = miss_i | miss_d;
                if (miss_i)
                    state_nxt = cache_pkg::fill_i;
                else if (miss_d)
                    state_nxt = cache_pkg::fill_d;
                else if (store_d)
                    state_nxt = fill_wb;
            end
            cache_pkg::fill_i: begin
                if (last_beat)
                    state_nxt = miss_d ? cache_pkg::fill_d : fill_wb;
            end
            cache_pkg::fill_d: begin
                if (last_beat)
                    state_nxt = fill_idle;
            end
            default: begin
                state_nxt = fill_idle;
            end
        endcase
    end

    ////////////////////
    // Request and return counters
    ////////////////////
    assign filling   = (state == cache_pkg::fill_i) || (state == cache_pkg::fill_d);
    assign last_beat = mem_vld && (ret_cnt == (`OFFSET_W)'(`BLOCK_WORDS - 1));

    // Both restart whenever the FSM moves on
    always_ff @(posedge clk) begin
        if (reset || (state_nxt != state)) begin
            req_cnt <= '0;
            ret_cnt <= '0;
        end else begin
            if (mem_en)
                req_cnt <= req_cnt + 1'b1;
            if (mem_vld)
                ret_cnt <= ret_cnt + 1'b1;
        end
    end

    // Enables stop after a full block while returns are still in flight
    assign mem_en    = filling && (req_cnt != (`OFFSET_W + 1)'(`BLOCK_WORDS));
    assign base_addr = (state == cache_pkg::fill_d) ? addr_d : addr_i;
    assign mem_addr  = {base_addr[`ADDR_W-1:`INDEX_LSB], req_cnt[`OFFSET_W-1:0], 1'b0};

    ////////////////////
    // Address delay line
    ////////////////////
    // Matches the memory pipeline so each return finds its own address
    always_ff @(posedge clk) begin
        addr_line[0] <= mem_addr;
        for (int k = 1; k < `MEM_LAT; k++) begin
            addr_line[k] <= addr_line[k-1];
        end
    end

    assign beat.data_we = mem_vld;
    assign beat.tag_we  = last_beat;
    assign beat.addr    = addr_line[`MEM_LAT-1];
    assign beat.data    = mem_data;

    assign fill_i = (state == cache_pkg::fill_i) ? beat : '0;
    assign fill_d = (state == cache_pkg::fill_d) ? beat : '0;

    ////////////////////
    // Checks
    ////////////////////
    // Idle issues no enable and has no return still in flight
    a_no_en_idle: assert property (@(posedge clk) disable iff (reset)
        (state == fill_idle) |-> !mem_en && !mem_vld);

    // A fill write must be the answer to an enable issued MEM_LAT cycles before
    a_we_has_vld: assert property (@(posedge clk) disable iff (reset)
        (fill_i.data_we || fill_d.data_we) |-> mem_vld && $past(mem_en, `MEM_LAT));

endmodule

//--- hdl/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

////////////////////
// Bus widths
////////////////////
`define ADDR_W      16
`define WORD_W      16

////////////////////
// Cache geometry
////////////////////
`define BLOCK_WORDS 8
`define SETS        8
`define OFFSET_W    $clog2(`BLOCK_WORDS)
`define INDEX_W     $clog2(`SETS)
// Bit 0 is the byte select inside a word
`define OFFSET_LSB  1
`define INDEX_LSB   (`OFFSET_LSB + `OFFSET_W)
`define TAG_LSB     (`INDEX_LSB + `INDEX_W)
`define TAG_W       (`ADDR_W - `TAG_LSB)

////////////////////
// Main memory
////////////////////
`define MEM_LAT     4
`define MEM_WORDS   (1 << (`ADDR_W - 1))
`define MEM_SEED    16'h5a5a

`endif

//--- hdl/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    ////////////////////
    // Vector types
    ////////////////////
    typedef logic [`ADDR_W-1:0]   addr_t;
    typedef logic [`WORD_W-1:0]   word_t;
    typedef logic [`TAG_W-1:0]    tag_t;
    typedef logic [`INDEX_W-1:0]  index_t;
    // Word position inside a block
    typedef logic [`OFFSET_W-1:0] offset_t;

    // Miss service FSM
    typedef enum logic [1:0] {
        fill_idle,
        fill_i,
        fill_d,
        fill_wb
    } fill_state_t;

    ////////////////////
    // Port bundles
    ////////////////////
    // One fill beat from the controller into a cache
    typedef struct packed {
        logic  data_we;
        logic  tag_we;
        addr_t addr;
        word_t data;
    } fill_wr_t;

    // One access from the core
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
    } core_req_t;

endpackage

//--- hdl/cache_top.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_top (
    input  logic                 clk,
    input  logic                 reset,
    input  cache_pkg::core_req_t i_req,
    output cache_pkg::word_t     i_rdata,
    input  cache_pkg::core_req_t d_req,
    output cache_pkg::word_t     d_rdata,
    output logic                 stall
);
    import cache_pkg::*;

    core_req_t i_req_rd;
    fill_wr_t  fill_wr_i;
    fill_wr_t  fill_wr_d;
    logic      miss_i;
    logic      miss_d;
    logic      store_d;
    logic      mem_en;
    logic      mem_vld;
    addr_t     mem_addr;
    word_t     mem_data;

    // Instruction side never stores
    always_comb begin
        i_req_rd    = i_req;
        i_req_rd.wr = 1'b0;
    end

    // Write-through strobe for a store hit
    assign store_d = d_req.wr && !miss_d && !stall;

    ////////////////////
    // Caches
    ////////////////////
    cache_array i_cache (
        .clk   (clk),
        .reset (reset),
        .req   (i_req_rd),
        .fill  (fill_wr_i),
        .miss  (miss_i),
        .rdata (i_rdata)
    );

    cache_array d_cache (
        .clk   (clk),
        .reset (reset),
        .req   (d_req),
        .fill  (fill_wr_d),
        .miss  (miss_d),
        .rdata (d_rdata)
    );

    ////////////////////
    // Miss service and memory
    ////////////////////
    cache_fill_ctrl u_fill_ctrl (
        .clk      (clk),
        .reset    (reset),
        .miss_i   (miss_i),
        .miss_d   (miss_d),
        .store_d  (store_d),
        .addr_i   (i_req.addr),
        .addr_d   (d_req.addr),
        .stall    (stall),
        .fill_i   (fill_wr_i),
        .fill_d   (fill_wr_d),
        .mem_en   (mem_en),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .mem_vld  (mem_vld)
    );

    main_mem u_main_mem (
        .clk     (clk),
        .reset   (reset),
        .rd_en   (mem_en),
        .rd_addr (mem_addr),
        .rdata   (mem_data),
        .vld     (mem_vld),
        .wr_en   (store_d),
        .wr_addr (d_req.addr),
        .wdata   (d_req.wdata)
    );

endmodule

//--- hdl/main_mem.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module main_mem (
    input  logic             clk,
    input  logic             reset,
    input  logic             rd_en,
    input  cache_pkg::addr_t rd_addr,
    output cache_pkg::word_t rdata,
    output logic             vld,
    input  logic             wr_en,
    input  cache_pkg::addr_t wr_addr,
    input  cache_pkg::word_t wdata
);
    import cache_pkg::*;

    word_t               mem [`MEM_WORDS];
    logic [`MEM_LAT-1:0] vld_pipe;
    addr_t               addr_pipe [`MEM_LAT];

    // Every word starts as its byte address xor the seed
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = word_t'(i * 2) ^ `MEM_SEED;
        end
    end

    ////////////////////
    // Write port
    ////////////////////
    always @(posedge clk) begin
        if (wr_en)
            mem[wr_addr[`ADDR_W-1:1]] <= wdata;
    end

    ////////////////////
    // Read pipeline
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset)
            vld_pipe <= '0;
        else
            vld_pipe <= {vld_pipe[`MEM_LAT-2:0], rd_en};
    end

    always_ff @(posedge clk) begin
        addr_pipe[0] <= rd_addr;
        for (int k = 1; k < `MEM_LAT; k++) begin
            addr_pipe[k] <= addr_pipe[k-1];
        end
    end

    // Array is read at the end of the pipe
    assign vld   = vld_pipe[`MEM_LAT-1];
    assign rdata = mem[addr_pipe[`MEM_LAT-1][`ADDR_W-1:1]];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module cache_top_tb -o cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- verif/cache_patterns.txt
// Columns: op port addr wdata expected, all in hex
// op 0 read, 1 write, 2 read that must hit, ff ends the list; port 0 I, 1 D, 2 both
// Instruction miss, then a hit in the same block
0 0 0104 0000 5b5e
2 0 010a 0000 5b50
// Data miss in set 3, a hit, a conflict miss in the same set, then a refill
0 1 0236 0000 586c
2 1 0230 0000 586a
0 1 0a36 0000 506c
0 1 0236 0000 586c
// Both caches miss under one stall, then both hit
0 2 0450 0000 5e0a
2 2 045e 0000 5e04
// Store hit writes through, seen again after an I-cache eviction and refill
0 0 0232 0000 5868
1 1 0238 beef 0000
0 1 0238 0000 beef
0 0 0a32 0000 5068
0 0 0238 0000 beef
// Store miss allocates the block, the other words keep their memory values
1 1 0670 1234 0000
0 1 0670 0000 1234
2 1 0672 0000 5c28
2 1 067e 0000 5c24
// End of list
ff 0 0000 0000 0000

//--- verif/cache_top_tb.sv
`timescale 1ns/1ps

module cache_top_tb;
    import cache_pkg::*;

    localparam int CLK_HALF           = 20;
    localparam int FIELDS             = 5;
    localparam int MAX_PATTERNS       = 64;
    localparam int CYCLES_PER_PATTERN = 40;

    // Pattern op and port codes
    localparam logic [15:0] OP_READ     = 16'h0000;
    localparam logic [15:0] OP_WRITE    = 16'h0001;
    localparam logic [15:0] OP_READ_HIT = 16'h0002;
    localparam logic [15:0] OP_END      = 16'h00ff;
    localparam logic [15:0] PORT_I      = 16'h0000;
    localparam logic [15:0] PORT_D      = 16'h0001;

    logic        clk;
    logic        reset;
    core_req_t   i_req;
    core_req_t   d_req;
    word_t       i_rdata;
    word_t       d_rdata;
    logic        stall;

    logic [15:0] pattern_mem [FIELDS*MAX_PATTERNS];
    int          n_patterns;
    logic        loaded;
    int          mismatches;
    int          tests_good;
    int          tests_bad;

    cache_top i_cache_top (
        .clk     (clk),
        .reset   (reset),
        .i_req   (i_req),
        .i_rdata (i_rdata),
        .d_req   (d_req),
        .d_rdata (d_rdata),
        .stall   (stall)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////
    task automatic compare(input string name, input logic [15:0] actual,
                           input logic [15:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
            mismatches++;
        end
    endtask

    // List ends at the first end marker
    function automatic int count_patterns();
        int n;
        n = 0;
        while (n < MAX_PATTERNS && pattern_mem[n*FIELDS] != OP_END)
            n++;
        return n;
    endfunction

    function automatic string op_name(input logic [15:0] op);
        case (op)
            OP_READ:     return "read";
            OP_WRITE:    return "write";
            OP_READ_HIT: return "read hit";
            default:     return "unknown";
        endcase
    endfunction

    task automatic run_pattern(input int idx);
        logic [15:0] op;
        logic [15:0] port;
        word_t       expected;
        core_req_t   req;
        int          errs_before;
        int          waited;
        op          = pattern_mem[idx*FIELDS];
        port        = pattern_mem[idx*FIELDS + 1];
        req.rd      = (op != OP_WRITE);
        req.wr      = (op == OP_WRITE);
        req.addr    = pattern_mem[idx*FIELDS + 2];
        req.wdata   = pattern_mem[idx*FIELDS + 3];
        expected    = pattern_mem[idx*FIELDS + 4];
        errs_before = mismatches;
        waited      = 0;

        @(posedge clk);
        if (port != PORT_D)
            i_req <= req;
        else
            i_req <= '0;
        if (port != PORT_I)
            d_req <= req;
        else
            d_req <= '0;

        @(negedge clk);
        // A hit must not stall at all
        if (op == OP_READ_HIT)
            compare("stall", {15'b0, stall}, 16'h0000);
        while (stall !== 1'b0) begin
            @(negedge clk);
            waited++;
        end
        if (op != OP_WRITE) begin
            if (port != PORT_D)
                compare("i_rdata", i_rdata, expected);
            if (port != PORT_I)
                compare("d_rdata", d_rdata, expected);
        end

        if (mismatches == errs_before)
            tests_good++;
        else
            tests_bad++;
        $display("test %0d: %s port %0d addr 0x%h, %0d stall cycles, %s", idx,
                 op_name(op), port, req.addr, waited,
                 (mismatches == errs_before) ? "ok" : "bad");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        int idx;
        reset      = 1'b1;
        i_req      = '0;
        d_req      = '0;
        mismatches = 0;
        tests_good = 0;
        tests_bad  = 0;
        loaded     = 1'b0;
        $readmemh("verif/cache_patterns.txt", pattern_mem);
        n_patterns = count_patterns();
        loaded     = 1'b1;

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        if (n_patterns == 0) begin
            $display("No test patterns were found in verif/cache_patterns.txt");
            tests_bad++;
        end
        for (idx = 0; idx < n_patterns; idx++)
            run_pattern(idx);

        @(posedge clk);
        i_req <= '0;
        d_req <= '0;
        repeat (2) @(posedge clk);

        $display("tests: %0d run, %0d good, %0d bad, %0d mismatches",
                 n_patterns, tests_good, tests_bad, mismatches);
        if (tests_bad == 0 && mismatches == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Watchdog scaled by the pattern count
    initial begin
        int limit;
        wait (loaded);
        limit = (n_patterns + 1) * CYCLES_PER_PATTERN;
        repeat (limit) @(posedge clk);
        $display("The run timed out after %0d clock cycles with patterns still pending", limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
